/* rtl/controlPkg.sv */
`default_nettype none

package controlPkg;

    // Sequencer states
    typedef enum logic [5:0] {
        fetchAddr     = 6'd0,
        fetchWait     = 6'd1,
        fetchLoad     = 6'd2,
        decode        = 6'd3,
        execute       = 6'd4,
        aluWriteback  = 6'd5,
        linkWriteback = 6'd7,
        immWriteback  = 6'd8,
        mulDivWait    = 6'd9,
        branchResolve = 6'd11,
        waitState     = 6'd63
    } ctrlStateT;

    typedef enum logic [5:0] {
        opRType = 6'b000000,
        opJump  = 6'b000010,
        opJal   = 6'b000011,
        opBeq   = 6'b000100,
        opBne   = 6'b000101,
        opBle   = 6'b000110,
        opBgt   = 6'b000111,
        opAddi  = 6'b001000,
        opAddiu = 6'b001001
    } opcodeT;

    typedef enum logic [5:0] {
        fnJr   = 6'b001000,
        fnMfhi = 6'b010000,
        fnMflo = 6'b010010,
        fnMult = 6'b011000,
        fnDiv  = 6'b011010,
        fnAdd  = 6'b100000,
        fnSub  = 6'b100010,
        fnAnd  = 6'b100100,
        fnSlt  = 6'b101010
    } functT;

    typedef enum logic [3:0] {
        clsAluReg, clsAluImm,
        clsSetLess, clsJumpReg, clsMoveHi, clsMoveLo,
        clsMultiply, clsDivide,
        clsJump, clsJumpLink,
        clsBranch, clsIllegal
    } instrClassT;

    typedef enum logic [1:0] {
        brEqual, brNotEqual, brLessEqual, brGreater
    } branchCondT;

    typedef enum logic [2:0] {
        aluPass    = 3'b000,
        aluAdd     = 3'b001,
        aluSub     = 3'b010,
        aluAnd     = 3'b011,
        aluCompare = 3'b111
    } aluOpT;

    typedef enum logic [2:0] {
        pcHold         = 3'b000,
        pcAluResult    = 3'b001,
        pcBranchTarget = 3'b100,
        pcJumpTarget   = 3'b101,
        pcRegA         = 3'b111
    } pcSourceT;

    typedef enum logic [2:0] {
        srcBRegB         = 3'b000,
        srcBImmediate    = 3'b010,
        srcBFour         = 3'b011,
        srcBBranchOffset = 3'b101
    } aluSrcBT;

    typedef enum logic [2:0] {
        destRt = 3'b000,
        destRd = 3'b001,
        destRa = 3'b010
    } regDestT;

    // aluOut is the latched register and aluResult the live ALU output
    typedef enum logic [3:0] {
        dataAluOut    = 4'b0000,
        dataHiLo      = 4'b0001,
        dataLessThan  = 4'b0010,
        dataAluResult = 4'b1001
    } regDataT;

endpackage

`default_nettype wire

/* rtl/decodeBus.sv */
`timescale 1ns/1ps
`default_nettype none

interface decodeBus import controlPkg::*; ();

    instrClassT instrClass;
    aluOpT      aluOp;
    branchCondT branchCond;
    logic       divSelect;

    modport producer (output instrClass, aluOp, branchCond, divSelect);

    modport sequencer (input instrClass);

    modport consumer (input instrClass, aluOp, branchCond, divSelect);

endinterface

`default_nettype wire

/* rtl/instrDecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instrDecoder import controlPkg::*; (
    input  opcodeT   opcode,
    input  functT    funct,
    decodeBus.producer dec
);

    always_comb begin
        dec.instrClass = clsIllegal;
        dec.aluOp      = aluPass;
        dec.branchCond = brEqual;
        dec.divSelect  = 1'b0;
        case (opcode)
            opRType: begin
                case (funct)
                    fnAdd: begin
                        dec.instrClass = clsAluReg;
                        dec.aluOp      = aluAdd;
                    end
                    fnSub: begin
                        dec.instrClass = clsAluReg;
                        dec.aluOp      = aluSub;
                    end
                    fnAnd: begin
                        dec.instrClass = clsAluReg;
                        dec.aluOp      = aluAnd;
                    end
                    fnSlt: begin
                        dec.instrClass = clsSetLess;
                        dec.aluOp      = aluCompare;
                    end
                    fnJr:   dec.instrClass = clsJumpReg;
                    fnMfhi: dec.instrClass = clsMoveHi;
                    fnMflo: dec.instrClass = clsMoveLo;
                    fnMult: dec.instrClass = clsMultiply;
                    fnDiv: begin
                        dec.instrClass = clsDivide;
                        dec.divSelect  = 1'b1;
                    end
                    default: dec.instrClass = clsIllegal;
                endcase
            end
            opJump: dec.instrClass = clsJump;
            opJal:  dec.instrClass = clsJumpLink;
            opAddi, opAddiu: begin
                dec.instrClass = clsAluImm;
                dec.aluOp      = aluAdd;
            end
            opBeq, opBne, opBle, opBgt: begin
                dec.instrClass = clsBranch;
                dec.aluOp      = aluCompare;
                // Low two opcode bits order the four compare branches
                dec.branchCond = branchCondT'(opcode[1:0]);
            end
            default: dec.instrClass = clsIllegal;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/phaseSequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module phaseSequencer import controlPkg::*; (
    input  logic      clock,
    input  logic      rst,
    decodeBus.sequencer dec,
    input  logic      multDone,
    input  logic      divDone,
    output ctrlStateT state
);

    ctrlStateT nextState;
    logic      unitDone;

    // Only the unit that was started can end the wait
    assign unitDone = (dec.instrClass == clsDivide) ? divDone : multDone;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= waitState;
        end else begin
            state <= nextState;
        end
    end

    always_comb begin
        nextState = waitState;
        case (state)
            fetchAddr: nextState = fetchWait;
            fetchWait: nextState = fetchLoad;
            fetchLoad: nextState = decode;
            decode:    nextState = execute;
            execute: begin
                case (dec.instrClass)
                    clsAluReg:   nextState = aluWriteback;
                    clsAluImm:   nextState = immWriteback;
                    clsJumpLink: nextState = linkWriteback;
                    clsBranch:   nextState = branchResolve;
                    clsMultiply,
                    clsDivide:   nextState = mulDivWait;
                    // jumps, slt, moves and undecodable codes end here
                    default:     nextState = waitState;
                endcase
            end
            aluWriteback,
            immWriteback,
            linkWriteback,
            branchResolve: nextState = waitState;
            mulDivWait: begin
                if (unitDone) begin
                    nextState = waitState;
                end else begin
                    nextState = mulDivWait;
                end
            end
            waitState: nextState = fetchAddr;
            default:   nextState = waitState;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/controlWordGen.sv */
`timescale 1ns/1ps
`default_nettype none

module controlWordGen import controlPkg::*; (
    input  ctrlStateT  state,
    decodeBus.consumer dec,
    input  logic       aluOverflow,
    input  logic       eq,
    input  logic       gt,
    input  logic       multDone,
    input  logic       divDone,
    output logic       pcWrite,
    output logic       irWrite,
    output logic [1:0] memAddr,
    output pcSourceT   pcSource,
    output aluOpT      aluControl,
    output aluSrcBT    aluSrcB,
    output logic       aluSrcA,
    output logic       regAWrite,
    output logic       regBWrite,
    output logic       aluOutWrite,
    output logic       regWrite,
    output regDestT    regDest,
    output regDataT    regData,
    output logic       hiLoSelect,
    output logic       hiSrc,
    output logic       loSrc,
    output logic       hiWrite,
    output logic       loWrite,
    output logic       multStart,
    output logic       divStart
);

    logic unitDone;
    logic branchTaken;

    assign unitDone = dec.divSelect ? divDone : multDone;

    always_comb begin
        case (dec.branchCond)
            brEqual:     branchTaken = eq;
            brNotEqual:  branchTaken = !eq;
            brLessEqual: branchTaken = !gt;
            default:     branchTaken = gt;
        endcase
    end

    // With no data stores, memory is always addressed by the PC
    assign memAddr = 2'b00;

    always_comb begin
        pcWrite     = 1'b0;
        irWrite     = 1'b0;
        pcSource    = pcHold;
        aluControl  = aluPass;
        aluSrcB     = srcBRegB;
        aluSrcA     = 1'b0;
        regAWrite   = 1'b0;
        regBWrite   = 1'b0;
        aluOutWrite = 1'b0;
        regWrite    = 1'b0;
        regDest     = destRt;
        regData     = dataAluOut;
        hiLoSelect  = 1'b0;
        hiSrc       = 1'b0;
        loSrc       = 1'b0;
        hiWrite     = 1'b0;
        loWrite     = 1'b0;
        multStart   = 1'b0;
        divStart    = 1'b0;
        case (state)
            fetchAddr: begin
                // PC + 4
                pcWrite    = 1'b1;
                pcSource   = pcAluResult;
                aluControl = aluAdd;
                aluSrcB    = srcBFour;
            end
            fetchLoad: irWrite = 1'b1;
            decode: begin
                // Branch target computed early into aluOut
                regAWrite   = 1'b1;
                regBWrite   = 1'b1;
                aluOutWrite = 1'b1;
                aluControl  = aluAdd;
                aluSrcB     = srcBBranchOffset;
            end
            execute: begin
                case (dec.instrClass)
                    clsAluReg, clsAluImm: begin
                        aluControl  = dec.aluOp;
                        aluSrcA     = 1'b1;
                        aluSrcB     = (dec.instrClass == clsAluImm) ? srcBImmediate : srcBRegB;
                        aluOutWrite = 1'b1;
                    end
                    clsJump: begin
                        pcWrite  = 1'b1;
                        pcSource = pcJumpTarget;
                    end
                    clsJumpLink: begin
                        pcWrite     = 1'b1;
                        pcSource    = pcJumpTarget;
                        // Return address captured before the PC changes
                        aluOutWrite = 1'b1;
                    end
                    clsJumpReg: begin
                        pcWrite  = 1'b1;
                        pcSource = pcRegA;
                    end
                    clsSetLess: begin
                        aluControl = dec.aluOp;
                        aluSrcA    = 1'b1;
                        regWrite   = 1'b1;
                        regDest    = destRd;
                        regData    = dataLessThan;
                    end
                    clsMoveHi, clsMoveLo: begin
                        regWrite   = 1'b1;
                        regDest    = destRd;
                        regData    = dataHiLo;
                        hiLoSelect = (dec.instrClass == clsMoveLo);
                    end
                    clsMultiply: multStart = 1'b1;
                    clsDivide:   divStart = 1'b1;
                    clsBranch: begin
                        aluControl = dec.aluOp;
                        aluSrcA    = 1'b1;
                        pcSource   = pcBranchTarget;
                    end
                    default: ;
                endcase
            end
            aluWriteback: begin
                // Overflow cancels the write and nothing else
                if (!aluOverflow) begin
                    regWrite = 1'b1;
                    regDest  = destRd;
                    regData  = dataAluResult;
                end
            end
            immWriteback: begin
                regWrite = 1'b1;
                regDest  = destRt;
            end
            linkWriteback: begin
                regWrite = 1'b1;
                regDest  = destRa;
            end
            branchResolve: begin
                aluControl = dec.aluOp;
                aluSrcA    = 1'b1;
                pcSource   = pcBranchTarget;
                pcWrite    = branchTaken;
            end
            mulDivWait: begin
                if (unitDone) begin
                    hiWrite = 1'b1;
                    loWrite = 1'b1;
                    hiSrc   = dec.divSelect;
                    loSrc   = dec.divSelect;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/mipsControl.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControl import controlPkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  opcodeT     opcode,
    input  functT      funct,
    input  logic       aluOverflow,
    input  logic       eq,
    input  logic       gt,
    input  logic       multDone,
    input  logic       divDone,
    output logic       pcWrite,
    output logic       irWrite,
    output logic [1:0] memAddr,
    output pcSourceT   pcSource,
    output aluOpT      aluControl,
    output aluSrcBT    aluSrcB,
    output logic       aluSrcA,
    output logic       regAWrite,
    output logic       regBWrite,
    output logic       aluOutWrite,
    output logic       regWrite,
    output regDestT    regDest,
    output regDataT    regData,
    output logic       hiLoSelect,
    output logic       hiSrc,
    output logic       loSrc,
    output logic       hiWrite,
    output logic       loWrite,
    output logic       multStart,
    output logic       divStart,
    output ctrlStateT  state
);

    decodeBus decBus ();

    instrDecoder decoder (
        .opcode (opcode),
        .funct  (funct),
        .dec    (decBus.producer)
    );

    phaseSequencer sequencer (
        .clock    (clock),
        .rst      (rst),
        .dec      (decBus.sequencer),
        .multDone (multDone),
        .divDone  (divDone),
        .state    (state)
    );

    controlWordGen wordGen (
        .state       (state),
        .dec         (decBus.consumer),
        .aluOverflow (aluOverflow),
        .eq          (eq),
        .gt          (gt),
        .multDone    (multDone),
        .divDone     (divDone),
        .pcWrite     (pcWrite),
        .irWrite     (irWrite),
        .memAddr     (memAddr),
        .pcSource    (pcSource),
        .aluControl  (aluControl),
        .aluSrcB     (aluSrcB),
        .aluSrcA     (aluSrcA),
        .regAWrite   (regAWrite),
        .regBWrite   (regBWrite),
        .aluOutWrite (aluOutWrite),
        .regWrite    (regWrite),
        .regDest     (regDest),
        .regData     (regData),
        .hiLoSelect  (hiLoSelect),
        .hiSrc       (hiSrc),
        .loSrc       (loSrc),
        .hiWrite     (hiWrite),
        .loWrite     (loWrite),
        .multStart   (multStart),
        .divStart    (divStart)
    );

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
    output logic clock,
    output logic rst
);

    localparam int halfPeriod  = 10;
    localparam int resetCycles = 16;

    initial begin
        clock = 1'b0;
        forever #halfPeriod clock = ~clock;
    end

    // Released just after an edge, like every other driven input
    initial begin
        rst = 1'b1;
        repeat (resetCycles) @(posedge clock);
        #1;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/controlChecker.sv */
`timescale 1ns/1ps
`default_nettype none

module controlChecker import controlPkg::*; (
    input  logic       clock,
    input  logic       rst,
    input  ctrlStateT  state,
    input  logic       multDone,
    input  logic       divDone,
    input  logic       pcWrite,
    input  logic       irWrite,
    input  logic [1:0] memAddr,
    input  pcSourceT   pcSource,
    input  aluOpT      aluControl,
    input  aluSrcBT    aluSrcB,
    input  logic       aluSrcA,
    input  logic       regAWrite,
    input  logic       regBWrite,
    input  logic       aluOutWrite,
    input  logic       regWrite,
    input  regDestT    regDest,
    input  regDataT    regData,
    input  logic       hiLoSelect,
    input  logic       hiSrc,
    input  logic       loSrc,
    input  logic       hiWrite,
    input  logic       loWrite,
    input  logic       multStart,
    input  logic       divStart,
    input  int         expCycles,
    input  logic       expRegWrite,
    input  logic [2:0] expRegDest,
    input  logic [3:0] expRegData,
    input  logic       expPcWrite,
    input  logic [2:0] expPcSource,
    input  logic [1:0] expHiLo,
    input  logic       expHiLoSel,
    output int         errorCount
);

    int         errors = 0;
    logic       active = 1'b0;
    logic       anyOutput;
    int         cycleCount;
    int         regWrites;
    int         hiWrites;
    int         multStarts;
    int         divStarts;
    logic       lastPcWrite;
    pcSourceT   lastPcSource;
    logic       selectedDone;

    // Held for the closing compare, since the driver moves on at fetchAddr
    int         wantCycles;
    logic       wantRegWrite;
    logic       wantPcWrite;
    logic [2:0] wantPcSource;
    logic [1:0] wantHiLo;

    assign errorCount   = errors;
    assign selectedDone = (expHiLo == 2'd2) ? divDone : multDone;
    assign anyOutput    = |{pcWrite, irWrite, memAddr, pcSource, aluControl, aluSrcB,
                            aluSrcA, regAWrite, regBWrite, aluOutWrite, regWrite, regDest,
                            regData, hiLoSelect, hiSrc, loSrc, hiWrite, loWrite,
                            multStart, divStart};

    task automatic expectValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Fail at %0t ns: %s expected %0h, actual %0h",
                     $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic reportProblem(input string what);
        $display("At %0t ns: %s", $time, what);
        errors++;
    endtask

    task automatic closeInstruction();
        expectValue("cycles", 32'(wantCycles), 32'(cycleCount));
        expectValue("regWrite pulses", 32'(wantRegWrite), 32'(regWrites));
        expectValue("final pcWrite", 32'(wantPcWrite), 32'(lastPcWrite));
        if (wantPcWrite) begin
            expectValue("final pcSource", 32'(wantPcSource), 32'(lastPcSource));
        end
        expectValue("hiWrite pulses", (wantHiLo != 2'd0) ? 1 : 0, 32'(hiWrites));
        expectValue("multStart pulses", (wantHiLo == 2'd1) ? 1 : 0, 32'(multStarts));
        expectValue("divStart pulses", (wantHiLo == 2'd2) ? 1 : 0, 32'(divStarts));
    endtask

    always @(negedge clock) begin
        if (!rst && state == fetchAddr) begin
            if (active) begin
                closeInstruction();
            end
            active       = 1'b1;
            cycleCount   = 1;
            regWrites    = 0;
            hiWrites     = 0;
            multStarts   = 0;
            divStarts    = 0;
            lastPcWrite  = 1'b0;
            lastPcSource = pcHold;
            wantCycles   = expCycles;
            wantRegWrite = expRegWrite;
            wantPcWrite  = expPcWrite;
            wantPcSource = expPcSource;
            wantHiLo     = expHiLo;
            // PC + 4 in the first fetch cycle
            expectValue("pcWrite", 1, 32'(pcWrite));
            expectValue("pcSource", 32'(pcAluResult), 32'(pcSource));
            expectValue("aluControl", 32'(aluAdd), 32'(aluControl));
            expectValue("aluSrcB", 32'(srcBFour), 32'(aluSrcB));
            expectValue("aluSrcA", 0, 32'(aluSrcA));
            expectValue("memAddr", 0, 32'(memAddr));
        end else if (!active) begin
            if (anyOutput) begin
                reportProblem("control outputs active before the first fetch");
            end
        end else begin
            cycleCount++;
            if (cycleCount == 3) begin
                expectValue("irWrite", 1, 32'(irWrite));
            end
            if (cycleCount == 4) begin
                // Register read and early branch target
                expectValue("regAWrite", 1, 32'(regAWrite));
                expectValue("regBWrite", 1, 32'(regBWrite));
                expectValue("aluOutWrite", 1, 32'(aluOutWrite));
                expectValue("aluControl", 32'(aluAdd), 32'(aluControl));
                expectValue("aluSrcB", 32'(srcBBranchOffset), 32'(aluSrcB));
            end
            if (regWrite) begin
                regWrites++;
                expectValue("regDest", 32'(expRegDest), 32'(regDest));
                expectValue("regData", 32'(expRegData), 32'(regData));
                expectValue("hiLoSelect", 32'(expHiLoSel), 32'(hiLoSelect));
            end
            if (state != waitState) begin
                lastPcWrite  = pcWrite;
                lastPcSource = pcSource;
            end
            if (multStart) begin
                multStarts++;
            end
            if (divStart) begin
                divStarts++;
            end
            if (hiWrite || loWrite) begin
                hiWrites++;
                expectValue("hiWrite", 1, 32'(hiWrite));
                expectValue("loWrite", 1, 32'(loWrite));
                expectValue("hiSrc", (expHiLo == 2'd2) ? 1 : 0, 32'(hiSrc));
                expectValue("loSrc", (expHiLo == 2'd2) ? 1 : 0, 32'(loSrc));
                if (!selectedDone) begin
                    reportProblem("hi/lo written while the selected done flag was low");
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/mipsControl_props.sv */
`timescale 1ns/1ps
`default_nettype none

module mipsControl_props import controlPkg::*; (
    input logic        clock,
    input logic        rst,
    input ctrlStateT   state,
    input logic        irWrite,
    input logic        multStart,
    input logic        divStart,
    input logic [31:0] outputWord
);

    int irFailures = 0;
    int strobeFailures = 0;
    int waitFailures = 0;
    int assertFailures;

    assign assertFailures = irFailures + strobeFailures + waitFailures;

    irWriteInFetchLoad: assert property (@(posedge clock) disable iff (rst)
        irWrite |-> (state == fetchLoad))
    else begin
        irFailures++;
        $error("irWrite asserted outside fetchLoad");
    end

    oneStartStrobe: assert property (@(posedge clock) !(multStart && divStart))
    else begin
        strobeFailures++;
        $error("multStart and divStart asserted together");
    end

    // Whole control word, reset included
    quietInWait: assert property (@(posedge clock)
        (state == waitState) |-> (outputWord == 32'd0))
    else begin
        waitFailures++;
        $error("control outputs active in waitState");
    end

endmodule

bind mipsControl mipsControl_props props (
    .clock      (clock),
    .rst        (rst),
    .state      (state),
    .irWrite    (irWrite),
    .multStart  (multStart),
    .divStart   (divStart),
    .outputWord ({pcWrite, irWrite, memAddr, pcSource, aluControl, aluSrcB, aluSrcA,
                  regAWrite, regBWrite, aluOutWrite, regWrite, regDest, regData,
                  hiLoSelect, hiSrc, loSrc, hiWrite, loWrite, multStart, divStart})
);

`default_nettype wire

/* testbench/controlTb.sv */
`timescale 1ns/1ps
`default_nettype none

module controlTb import controlPkg::*; ();

    localparam int fieldCount    = 14;
    localparam int timeoutCycles = 200;

    logic       clock;
    logic       rst;
    opcodeT     opcode;
    functT      funct;
    logic       aluOverflow;
    logic       eq;
    logic       gt;
    logic       multDone;
    logic       divDone;
    logic       pcWrite;
    logic       irWrite;
    logic [1:0] memAddr;
    pcSourceT   pcSource;
    aluOpT      aluControl;
    aluSrcBT    aluSrcB;
    logic       aluSrcA;
    logic       regAWrite;
    logic       regBWrite;
    logic       aluOutWrite;
    logic       regWrite;
    regDestT    regDest;
    regDataT    regData;
    logic       hiLoSelect;
    logic       hiSrc;
    logic       loSrc;
    logic       hiWrite;
    logic       loWrite;
    logic       multStart;
    logic       divStart;
    ctrlStateT  state;

    // Expectations for the instruction in flight
    int         expCycles;
    logic       expRegWrite;
    logic [2:0] expRegDest;
    logic [3:0] expRegData;
    logic       expPcWrite;
    logic [2:0] expPcSource;
    logic [1:0] expHiLo;
    logic       expHiLoSel;
    int         errorCount;

    logic [31:0] traceMem [0:511];
    logic [31:0] randState;
    int          runErrors;
    int          instrTotal;

    clockGen clkGen (
        .clock (clock),
        .rst   (rst)
    );

    mipsControl uut (.*);

    controlChecker outputCheck (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] traceField(input int pos);
        return traceMem[pos[8:0]];
    endfunction

    task automatic waitForFetch(output logic found);
        int n;
        found = 1'b0;
        for (n = 0; n < timeoutCycles && !found; n++) begin
            @(posedge clock);
            #1;
            found = (state == fetchAddr);
        end
    endtask

    // Called in fetchAddr; returns at the next fetchAddr
    task automatic runInstruction(input int base, output logic finished);
        logic [31:0] entry [0:fieldCount-1];
        logic [31:0] doneMax;
        int          doneDelay;
        int          waitCycles;
        int          n;
        for (n = 0; n < fieldCount; n++) begin
            entry[n[3:0]] = traceField(base + n);
        end
        doneMax   = entry[5];
        doneDelay = 0;
        if (doneMax != 0) begin
            randState = xorshift(randState);
            doneDelay = 1 + int'(randState % doneMax);
        end
        opcode      = opcodeT'(entry[0][5:0]);
        funct       = functT'(entry[1][5:0]);
        aluOverflow = entry[2][0];
        eq          = entry[3][0];
        gt          = entry[4][0];
        expCycles   = int'(entry[6]) + doneDelay;
        expRegWrite = entry[7][0];
        expRegDest  = entry[8][2:0];
        expRegData  = entry[9][3:0];
        expPcWrite  = entry[10][0];
        expPcSource = entry[11][2:0];
        expHiLo     = entry[12][1:0];
        expHiLoSel  = entry[13][0];
        waitCycles  = 0;
        finished    = 1'b0;
        for (n = 0; n < timeoutCycles && !finished; n++) begin
            @(posedge clock);
            #1;
            if (state == mulDivWait) begin
                waitCycles++;
            end
            multDone = (state == mulDivWait) && (waitCycles == doneDelay) && (expHiLo == 2'd1);
            divDone  = (state == mulDivWait) && (waitCycles == doneDelay) && (expHiLo == 2'd2);
            finished = (state == fetchAddr);
        end
    endtask

    initial begin
        logic found;
        int   idx;
        opcode      = opRType;
        funct       = fnAdd;
        aluOverflow = 1'b0;
        eq          = 1'b0;
        gt          = 1'b0;
        multDone    = 1'b0;
        divDone     = 1'b0;
        expCycles   = 0;
        expRegWrite = 1'b0;
        expRegDest  = 3'd0;
        expRegData  = 4'd0;
        expPcWrite  = 1'b0;
        expPcSource = 3'd0;
        expHiLo     = 2'd0;
        expHiLoSel  = 1'b0;
        randState   = 32'he735c200;
        runErrors   = 0;
        $readmemh("testbench/instrTrace.txt", traceMem);
        instrTotal = int'(traceMem[0]);
        if (instrTotal <= 0) begin
            $display("Instruction trace is empty or could not be read");
            runErrors++;
        end
        waitForFetch(found);
        if (!found) begin
            $display("Timed out waiting for the first instruction fetch");
            runErrors++;
        end
        for (idx = 0; idx < instrTotal && runErrors == 0; idx++) begin
            runInstruction(1 + idx * fieldCount, found);
            if (!found) begin
                $display("Timed out waiting for instruction %0d to return to fetch", idx);
                runErrors++;
            end
        end
        // Last instruction is closed by the checker at this falling edge
        @(negedge clock);
        #1;
        $display("Errors: %0d compare, %0d assertion, %0d run",
                 errorCount, uut.props.assertFailures, runErrors);
        if (errorCount == 0 && uut.props.assertFailures == 0 && runErrors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/instrTrace.txt */
// First word: instruction count. Then per line, in hex:
// opcode funct ovf eq gt doneMax cycles regWr dest data pcWr pcSrc hiLo(1 mult 2 div) hiLoSel
17
00 20 0 0 0 0 7 1 1 9 0 0 0 0  // add
00 22 0 0 0 0 7 1 1 9 0 0 0 0  // sub
00 24 0 0 0 0 7 1 1 9 0 0 0 0  // and
00 20 1 0 0 0 7 0 0 0 0 0 0 0  // add with overflow
08 00 0 0 0 0 7 1 0 0 0 0 0 0  // addi
09 00 0 0 0 0 7 1 0 0 0 0 0 0  // addiu
03 00 0 0 0 0 7 1 2 0 0 0 0 0  // jal
00 2a 0 0 0 0 6 1 1 2 0 0 0 0  // slt
00 10 0 0 0 0 6 1 1 1 0 0 0 0  // mfhi
00 12 0 0 0 0 6 1 1 1 0 0 0 1  // mflo
02 00 0 0 0 0 6 0 0 0 1 5 0 0  // j
00 08 0 0 0 0 6 0 0 0 1 7 0 0  // jr
04 00 0 1 1 0 7 0 0 0 1 4 0 0  // beq taken
04 00 0 0 1 0 7 0 0 0 0 0 0 0  // beq not taken
05 00 0 0 0 0 7 0 0 0 1 4 0 0  // bne taken
05 00 0 1 0 0 7 0 0 0 0 0 0 0  // bne not taken
06 00 0 1 0 0 7 0 0 0 1 4 0 0  // ble taken
06 00 0 0 1 0 7 0 0 0 0 0 0 0  // ble not taken
07 00 0 0 1 0 7 0 0 0 1 4 0 0  // bgt taken
07 00 0 1 0 0 7 0 0 0 0 0 0 0  // bgt not taken
00 18 0 0 0 5 6 0 0 0 0 0 1 0  // mult
00 1a 0 0 0 6 6 0 0 0 0 0 2 0  // div
3f 00 0 0 0 0 6 0 0 0 0 0 0 0  // illegal opcode

/* compile.f */
rtl/controlPkg.sv
rtl/decodeBus.sv
rtl/instrDecoder.sv
rtl/phaseSequencer.sv
rtl/controlWordGen.sv
rtl/mipsControl.sv
testbench/clockGen.sv
testbench/controlChecker.sv
testbench/mipsControl_props.sv
testbench/controlTb.sv

/* run.sh */
#!/usr/bin/env bash
# Build with Verilator and run from the project root so the trace path resolves
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module controlTb -Mdir obj_dir \
    && ./obj_dir/VcontrolTb +verilator+error+limit+1000 \
    | tee /dev/stderr \
    | grep "Test completed successfully" > /dev/null \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
